// File: bp_pkg.sv
// ============================
// bp_pkg
// shared types and constants for the predictor
// ============================

package bp_pkg;

    // fetch pc or branch target
    typedef logic [31:0] addr_t;

    // 2-bit direction counter
    // 00 strong not taken
    // 01 weak not taken
    // 10 weak taken
    // 11 strong taken
    // msb set means predict taken
    typedef logic [1:0] ctr_t;

    // value after a clear or a non-branch update
    localparam ctr_t ctr_init = 2'b00;

    // byte step to the sequential instruction
    // no compressed instructions, so always 4
    localparam int fall_through_step = 4;

    // init fsm of the control block
    // sweep clears every table entry after reset
    // run accepts lookups and updates
    typedef enum logic [0:0] {
        st_sweep = 1'b0,
        st_run   = 1'b1
    } init_state_t;

    // the index width follows the index_bits parameter
    // of each module, so there is no index type here
    // index is pc[index_bits+1:2]

endpackage

// File: bp_update_if.sv
// ============================
// bp_update_if
// registered resolved-branch update bus
// ============================

`timescale 1ns/1ps

interface bp_update_if #(
    parameter int index_bits = 6
);
    import bp_pkg::*;

    // one-cycle write strobe
    logic                  valid;
    // resolved op was a branch
    logic                  is_br;
    // resolved direction
    logic                  taken;
    // pc of the resolved op, also the btb tag
    addr_t                 pc;
    // resolved target, written only when taken
    addr_t                 target;
    // table index, computed once in the control block
    logic [index_bits-1:0] idx;

    // driven by the control block
    modport ctrl (output valid, is_br, taken, pc, target, idx);

    // seen by the btb and the counter table
    modport tables (input valid, is_br, taken, pc, target, idx);

endinterface

// File: btb_table.sv
// ============================
// btb_table
// direct-mapped tag, valid and target store
// ============================

`timescale 1ns/1ps

module btb_table #(
    parameter int index_bits = 6
) (
    input  logic                  clk,
    input  logic                  arst_n,
    bp_update_if.tables           upd,
    input  logic                  sweep_en,
    input  logic [index_bits-1:0] sweep_idx,
    input  logic [index_bits-1:0] lookup_idx,
    input  bp_pkg::addr_t         pc,
    output logic                  hit,
    output bp_pkg::addr_t         tgt
);
    import bp_pkg::*;

    localparam int depth = 1 << index_bits;

    // valid bits are flops so reset can clear them
    logic [depth-1:0] valid_q;

    // full pc kept as tag
    addr_t tag_mem [depth];
    // taken target per entry
    addr_t target_mem [depth];

    // update write enable, sweep has priority
    logic upd_we;

    assign upd_we = upd.valid && !sweep_en;

    // valid bits
    // sweep clears one entry per cycle
    // a non-branch update drops the entry
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (sweep_en) begin
            valid_q[sweep_idx] <= 1'b0;
        end else if (upd.valid) begin
            valid_q[upd.idx] <= upd.is_br;
        end
    end

    // tag and target arrays
    always_ff @(posedge clk) begin
        if (upd_we && upd.is_br) begin
            tag_mem[upd.idx] <= upd.pc;
            // not-taken branch keeps the old target
            if (upd.taken) begin
                target_mem[upd.idx] <= upd.target;
            end
        end
    end

    // lookup
    // compare against the whole pc
    // so pcs sharing an index but differing above it miss
    always_comb begin
        hit = valid_q[lookup_idx] && (tag_mem[lookup_idx] == pc);
        tgt = target_mem[lookup_idx];
    end

endmodule

// File: counter_table.sv
// ============================
// counter_table
// 2-bit saturating direction counters
// ============================

`timescale 1ns/1ps

module counter_table #(
    parameter int index_bits = 6
) (
    input  logic                  clk,
    bp_update_if.tables           upd,
    input  logic                  sweep_en,
    input  logic [index_bits-1:0] sweep_idx,
    input  logic [index_bits-1:0] lookup_idx,
    output logic                  ctr_msb
);
    import bp_pkg::*;

    localparam int depth = 1 << index_bits;

    // saturation limits
    localparam ctr_t ctr_strong_taken     = 2'b11;
    localparam ctr_t ctr_strong_not_taken = 2'b00;

    // one counter per entry
    ctr_t ctr_mem [depth];

    // counter at the update index and its next value
    ctr_t ctr_cur;
    ctr_t ctr_nxt;

    assign ctr_cur = ctr_mem[upd.idx];

    // step rule
    // non-branch goes back to ctr_init
    // branch moves one step toward the outcome, held at the ends
    always_comb begin
        if (!upd.is_br) begin
            ctr_nxt = ctr_init;
        end else if (upd.taken) begin
            if (ctr_cur == ctr_strong_taken) begin
                ctr_nxt = ctr_cur;
            end else begin
                ctr_nxt = ctr_cur + ctr_t'(1);
            end
        end else begin
            if (ctr_cur == ctr_strong_not_taken) begin
                ctr_nxt = ctr_cur;
            end else begin
                ctr_nxt = ctr_cur - ctr_t'(1);
            end
        end
    end

    // sweep write wins, update ignored meanwhile
    always_ff @(posedge clk) begin
        if (sweep_en) begin
            ctr_mem[sweep_idx] <= ctr_init;
        end else if (upd.valid) begin
            ctr_mem[upd.idx] <= ctr_nxt;
        end
    end

    // taken when msb set (10, 11)
    assign ctr_msb = ctr_mem[lookup_idx][1];

endmodule

// File: predictor_ctrl.sv
// ============================
// predictor_ctrl
// init sweep, update register, next-pc select
// ============================

`timescale 1ns/1ps

module predictor_ctrl #(
    parameter int index_bits = 6
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  bp_pkg::addr_t         pc,
    input  logic                  upd_valid,
    input  logic                  upd_is_br,
    input  logic                  upd_taken,
    input  bp_pkg::addr_t         upd_pc,
    input  bp_pkg::addr_t         upd_target,
    bp_update_if.ctrl             upd,
    output logic                  sweep_en,
    output logic [index_bits-1:0] sweep_idx,
    output logic [index_bits-1:0] lookup_idx,
    input  logic                  hit,
    input  bp_pkg::addr_t         tgt,
    input  logic                  ctr_msb,
    output bp_pkg::addr_t         next_pc,
    output logic                  ready
);
    import bp_pkg::*;

    localparam int depth = 1 << index_bits;
    // index of the last entry the sweep clears
    localparam logic [index_bits-1:0] last_idx = index_bits'(depth - 1);

    init_state_t           state_q;
    logic [index_bits-1:0] sweep_cnt_q;

    // registered update
    logic                  upd_valid_q;
    logic                  upd_is_br_q;
    logic                  upd_taken_q;
    addr_t                 upd_pc_q;
    addr_t                 upd_target_q;
    logic [index_bits-1:0] upd_idx_q;

    // init fsm
    // one entry cleared per cycle, 2^index_bits cycles total
    // leaves st_sweep on the edge that clears the last entry
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= st_sweep;
            sweep_cnt_q <= '0;
        end else begin
            case (state_q)
                st_sweep: begin
                    sweep_cnt_q <= sweep_cnt_q + 1'b1;
                    if (sweep_cnt_q == last_idx) begin
                        state_q <= st_run;
                    end
                end
                default: begin
                    state_q <= st_run;
                end
            endcase
        end
    end

    assign sweep_en  = (state_q == st_sweep);
    assign sweep_idx = sweep_cnt_q;
    assign ready     = (state_q == st_run);

    // update strobe, dropped while not ready
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            upd_valid_q <= 1'b0;
        end else begin
            upd_valid_q <= upd_valid && ready;
        end
    end

    // update payload, index taken once here
    always_ff @(posedge clk) begin
        upd_is_br_q  <= upd_is_br;
        upd_taken_q  <= upd_taken;
        upd_pc_q     <= upd_pc;
        upd_target_q <= upd_target;
        upd_idx_q    <= upd_pc[index_bits+1:2];
    end

    // tables write one edge later
    assign upd.valid  = upd_valid_q;
    assign upd.is_br  = upd_is_br_q;
    assign upd.taken  = upd_taken_q;
    assign upd.pc     = upd_pc_q;
    assign upd.target = upd_target_q;
    assign upd.idx    = upd_idx_q;

    // lookup, same cycle as pc
    assign lookup_idx = pc[index_bits+1:2];

    // stored target only on a hit predicted taken
    // fall-through otherwise and during the sweep
    always_comb begin
        if (ready && hit && ctr_msb) begin
            next_pc = tgt;
        end else begin
            next_pc = pc + addr_t'(fall_through_step);
        end
    end

endmodule

// File: branch_predictor.sv
// ============================
// branch_predictor
// btb next-fetch-address predictor top
// ============================

`timescale 1ns/1ps

module branch_predictor #(
    parameter int index_bits = 6
) (
    input  logic          clk,
    input  logic          arst_n,
    input  bp_pkg::addr_t pc,
    output bp_pkg::addr_t next_pc,
    output logic          ready,
    input  logic          upd_valid,
    input  logic          upd_is_br,
    input  logic          upd_taken,
    input  bp_pkg::addr_t upd_pc,
    input  bp_pkg::addr_t upd_target
);
    import bp_pkg::*;

    // sweep and lookup to both tables
    logic                  sweep_en;
    logic [index_bits-1:0] sweep_idx;
    logic [index_bits-1:0] lookup_idx;

    // lookup results
    logic                  hit;
    addr_t                 tgt;
    logic                  ctr_msb;

    // registered update to both tables
    bp_update_if #(.index_bits(index_bits)) upd_bus ();

    predictor_ctrl #(.index_bits(index_bits)) ctrl0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .pc         (pc),
        .upd_valid  (upd_valid),
        .upd_is_br  (upd_is_br),
        .upd_taken  (upd_taken),
        .upd_pc     (upd_pc),
        .upd_target (upd_target),
        .upd        (upd_bus),
        .sweep_en   (sweep_en),
        .sweep_idx  (sweep_idx),
        .lookup_idx (lookup_idx),
        .hit        (hit),
        .tgt        (tgt),
        .ctr_msb    (ctr_msb),
        .next_pc    (next_pc),
        .ready      (ready)
    );

    btb_table #(.index_bits(index_bits)) btb0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .upd        (upd_bus),
        .sweep_en   (sweep_en),
        .sweep_idx  (sweep_idx),
        .lookup_idx (lookup_idx),
        .pc         (pc),
        .hit        (hit),
        .tgt        (tgt)
    );

    counter_table #(.index_bits(index_bits)) ctr0 (
        .clk        (clk),
        .upd        (upd_bus),
        .sweep_en   (sweep_en),
        .sweep_idx  (sweep_idx),
        .lookup_idx (lookup_idx),
        .ctr_msb    (ctr_msb)
    );

endmodule

// File: tb_branch_predictor.sv
// ==============================
// tb_branch_predictor
// replays the test vectors and checks next_pc
// ==============================

`timescale 1ns/1ps

module tb_branch_predictor;
    import bp_pkg::*;

    localparam int index_bits    = 6;
    localparam int vec_addr_bits = 9;
    localparam int vec_words     = 1 << vec_addr_bits;
    localparam int fields        = 6;
    localparam int max_vectors   = vec_words / fields;
    localparam int ready_timeout = 200;
    // one entry cleared per cycle
    localparam int sweep_len     = 1 << index_bits;

    // op codes in the vector file
    localparam logic [31:0] op_lookup = 32'h0;
    localparam logic [31:0] op_update = 32'h1;
    localparam logic [31:0] op_end    = 32'hf;

    logic  clk;
    logic  arst_n;
    addr_t pc;
    addr_t next_pc;
    logic  ready;
    logic  upd_valid;
    logic  upd_is_br;
    logic  upd_taken;
    addr_t upd_pc;
    addr_t upd_target;

    // flat vector store of six words per line
    logic [31:0]              vec_mem [vec_words];
    logic [vec_addr_bits-1:0] rd_addr;

    int errors;
    int checks;
    int vec_count;
    int sweep_cycles;
    bit done;
    bit ready_ok;

    // fields of the current vector
    logic [31:0] v_op;
    addr_t       v_pc;
    logic [31:0] v_is_br;
    logic [31:0] v_taken;
    addr_t       v_target;
    addr_t       v_exp;

    branch_predictor #(.index_bits(index_bits)) dut0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .pc         (pc),
        .next_pc    (next_pc),
        .ready      (ready),
        .upd_valid  (upd_valid),
        .upd_is_br  (upd_is_br),
        .upd_taken  (upd_taken),
        .upd_pc     (upd_pc),
        .upd_target (upd_target)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // 1 ns past the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // bounded wait for the sweep to end
    // cycles counts the edges waited
    task automatic wait_ready(output bit ok, output int cycles);
        cycles = 0;
        while (ready !== 1'b1 && cycles < ready_timeout) begin
            next_cycle();
            cycles = cycles + 1;
        end
        ok = (ready === 1'b1);
    endtask

    task automatic fetch_word(output logic [31:0] word);
        word    = vec_mem[rd_addr];
        rd_addr = rd_addr + 1'b1;
    endtask

    task automatic load_vector();
        fetch_word(v_op);
        fetch_word(v_pc);
        fetch_word(v_is_br);
        fetch_word(v_taken);
        fetch_word(v_target);
        fetch_word(v_exp);
    endtask

    // strobe for one cycle and idle for one
    task automatic send_update();
        upd_valid  = 1'b1;
        upd_is_br  = v_is_br[0];
        upd_taken  = v_taken[0];
        upd_pc     = v_pc;
        upd_target = v_target;
        // edge N registers the strobe
        next_cycle();
        upd_valid = 1'b0;
        // edge N+1 writes the tables
        next_cycle();
    endtask

    // combinational path sampled mid-cycle
    task automatic probe_next_pc();
        pc = v_pc;
        #5;
        check_addr("next_pc", next_pc, v_exp);
        next_cycle();
    endtask

    initial begin
        arst_n       = 1'b0;
        pc           = '0;
        upd_valid    = 1'b0;
        upd_is_br    = 1'b0;
        upd_taken    = 1'b0;
        upd_pc       = '0;
        upd_target   = '0;
        errors       = 0;
        checks       = 0;
        vec_count    = 0;
        sweep_cycles = 0;
        done         = 1'b0;
        ready_ok     = 1'b0;
        rd_addr      = '0;

        $readmemh("bp_tests.mem", vec_mem);

        // reset held 3 cycles
        repeat (3) @(posedge clk);
        check_level("ready", ready, 1'b0);
        #1;
        arst_n = 1'b1;

        // fall-through while the sweep runs
        pc = 32'h0000_0200;
        #5;
        check_level("ready", ready, 1'b0);
        check_addr("next_pc", next_pc, 32'h0000_0204);
        next_cycle();

        // first sweep edge already passed
        wait_ready(ready_ok, sweep_cycles);
        if (!ready_ok) begin
            errors = errors + 1;
            $display("ERROR: ready never rose within %0d cycles", ready_timeout);
        end else begin
            if (sweep_cycles + 1 != sweep_len) begin
                errors = errors + 1;
                $display("ERROR: ready rose after %0d sweep cycles instead of %0d",
                         sweep_cycles + 1, sweep_len);
            end
            while (!done && vec_count < max_vectors) begin
                load_vector();
                if (v_op == op_end) begin
                    done = 1'b1;
                end else if (v_op == op_lookup) begin
                    probe_next_pc();
                    vec_count = vec_count + 1;
                end else if (v_op == op_update) begin
                    send_update();
                    vec_count = vec_count + 1;
                end else begin
                    errors = errors + 1;
                    $display("ERROR: unknown op %h in vector %0d", v_op, vec_count);
                    done = 1'b1;
                end
            end
            if (!done) begin
                errors = errors + 1;
                $display("ERROR: test vectors have no end marker");
            end
            if (vec_count == 0) begin
                errors = errors + 1;
                $display("ERROR: no test vectors were loaded");
            end
            // ready stays up once the sweep is done
            check_level("ready", ready, 1'b1);
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: bp_tests.mem
// op pc is_br taken target expected_next_pc, all hex
// op 0 lookup, 1 update, f end of vectors
// cold lookups after the sweep
0 00001000 0 0 00000000 00001004
0 00002040 0 0 00000000 00002044
0 000010fc 0 0 00000000 00001100
// taken once, counter 01
1 00001010 1 1 00003000 00000000
0 00001010 0 0 00000000 00001014
// taken twice, counter 10
1 00001010 1 1 00003000 00000000
0 00001010 0 0 00000000 00003000
// saturate at 11
1 00001010 1 1 00003000 00000000
1 00001010 1 1 00003000 00000000
0 00001010 0 0 00000000 00003000
// one not-taken, counter 10
1 00001010 1 0 00000000 00000000
0 00001010 0 0 00000000 00003000
// second not-taken, counter 01
1 00001010 1 0 00000000 00000000
0 00001010 0 0 00000000 00001014
// train, then clear with a non-branch
1 00001020 1 1 00004000 00000000
1 00001020 1 1 00004000 00000000
0 00001020 0 0 00000000 00004000
1 00001020 0 0 00000000 00000000
0 00001020 0 0 00000000 00001024
// retrain needs two taken updates
1 00001020 1 1 00004000 00000000
0 00001020 0 0 00000000 00001024
1 00001020 1 1 00004000 00000000
0 00001020 0 0 00000000 00004000
// aliasing, 00001130 shares the index of 00001030
1 00001030 1 1 00005000 00000000
1 00001030 1 1 00005000 00000000
0 00001030 0 0 00000000 00005000
0 00001130 0 0 00000000 00001134
1 00001130 1 1 00006000 00000000
0 00001130 0 0 00000000 00006000
0 00001030 0 0 00000000 00001034
// target replaced by taken, kept by not-taken
1 00001040 1 1 00007000 00000000
1 00001040 1 1 00007000 00000000
0 00001040 0 0 00000000 00007000
1 00001040 1 1 00007800 00000000
0 00001040 0 0 00000000 00007800
1 00001040 1 0 00009999 00000000
0 00001040 0 0 00000000 00007800
f 00000000 0 0 00000000 00000000

// File: vlog.f
bp_pkg.sv
bp_update_if.sv
btb_table.sv
counter_table.sv
predictor_ctrl.sv
branch_predictor.sv
tb_branch_predictor.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the branch predictor testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_branch_predictor -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_branch_predictor)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qxF "ALL CHECKS PASSED"; then
    exit 0
fi

echo "simulation did not pass"
exit 1
